// File: hdl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int ARF_W    = 5;
    localparam int ROB_W    = 6;
    localparam int WORD_W   = 32;

    // architectural registers, r0 hardwired to zero
    localparam int ARF_REGS = 32;

    // headroom kept free in the reorder buffer
    localparam int ROB_MARGIN = 4;

    typedef logic [ARF_W-1:0]  arf_id_t;
    typedef logic [ROB_W-1:0]  rob_id_t;
    typedef logic [WORD_W-1:0] word_t;

    // check flips on every rename of a register, so a fresh speculative
    // mapping never equals a stale committed one with the same rob id
    typedef struct packed {
        logic    check;
        rob_id_t rob_id;
    } rat_entry_t;

endpackage

`default_nettype wire

// File: hdl/retire_if.sv
`default_nettype none

interface retire_if;

    // one bit or field per retire lane
    logic [1:0]                  valid;
    logic [1:0]                  w_valid;
    rename_pkg::arf_id_t [1:0]   arf_id;
    rename_pkg::rob_id_t [1:0]   rob_id;
    logic [1:0]                  check;
    rename_pkg::word_t [1:0]     data;

    modport top_mp (
        output valid,
        output w_valid,
        output arf_id,
        output rob_id,
        output check,
        output data
    );

    modport stage_mp (
        input valid,
        input w_valid,
        input arf_id,
        input rob_id,
        input check,
        input data
    );

endinterface

`default_nettype wire

// File: hdl/map_table.sv
`default_nettype none

module map_table #(
    parameter int R_PORTS = 4,
    parameter bit FORWARD = 1'b0
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  clr_i,
    input  rename_pkg::arf_id_t [R_PORTS-1:0]     raddr_i,
    output rename_pkg::rat_entry_t [R_PORTS-1:0]  rdata_o,
    input  rename_pkg::arf_id_t [1:0]             waddr_i,
    input  logic [1:0]                            we_i,
    input  rename_pkg::rat_entry_t [1:0]          wdata_i
);

    rename_pkg::rat_entry_t [rename_pkg::ARF_REGS-1:0] tbl_q;

    // lane 1 is written last and wins on an address clash
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tbl_q <= '0;
        end else if (clr_i) begin
            tbl_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    tbl_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < R_PORTS; p++) begin
            rdata_o[p] = tbl_q[raddr_i[p]];
            if (FORWARD) begin
                for (int w = 0; w < 2; w++) begin
                    if (we_i[w] && (waddr_i[w] == raddr_i[p])) begin
                        rdata_o[p] = wdata_i[w];
                    end
                end
            end
        end
    end

    // r0 has no producer, callers must filter it out
    for (genvar w = 0; w < 2; w++) begin : g_wchk
        a_no_r0_write: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            we_i[w] |-> (waddr_i[w] != '0)
        ) else $error("map_table: write to r0 on port %0d", w);
    end

endmodule

`default_nettype wire

// File: hdl/arf.sv
`default_nettype none

module arf (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  rename_pkg::arf_id_t [3:0]     raddr_i,
    output rename_pkg::word_t [3:0]       rdata_o,
    input  rename_pkg::arf_id_t [1:0]     waddr_i,
    input  logic [1:0]                    we_i,
    input  rename_pkg::word_t [1:0]       wdata_i
);

    rename_pkg::word_t [rename_pkg::ARF_REGS-1:0] regs_q;
    logic [1:0] wr_en;

    // r0 is never written
    assign wr_en[0] = we_i[0] & (waddr_i[0] != '0);
    assign wr_en[1] = we_i[1] & (waddr_i[1] != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    regs_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // same-cycle retire data bypasses the array, lane 1 last
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = regs_q[raddr_i[p]];
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w] && (waddr_i[w] == raddr_i[p])) begin
                    rdata_o[p] = wdata_i[w];
                end
            end
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_stage.sv
`default_nettype none

module rename_stage #(
    parameter int ROB_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    retire_if.stage_mp                    retire,
    // decode side
    input  logic                          dec_valid_i,
    output logic                          dec_ready_o,
    input  logic [1:0]                    dec_r_valid_i,
    input  logic [1:0]                    dec_w_reg_i,
    input  rename_pkg::arf_id_t [3:0]     dec_rs_i,
    input  rename_pkg::arf_id_t [1:0]     dec_rd_i,
    input  logic [3:0]                    dec_reg_need_i,
    input  rename_pkg::word_t             dec_pc_i,
    // issue side
    input  logic                          ren_ready_i,
    output logic [1:0]                    ren_r_valid_o,
    output rename_pkg::arf_id_t [1:0]     ren_areg_o,
    output rename_pkg::rob_id_t [1:0]     ren_preg_o,
    output logic [1:0]                    ren_check_o,
    output rename_pkg::rob_id_t [3:0]     ren_src_preg_o,
    output rename_pkg::word_t [3:0]       ren_arf_data_o,
    output logic [3:0]                    ren_data_valid_o,
    output rename_pkg::word_t             ren_pc_o
);

    localparam int OCC_W = $clog2(ROB_DEPTH + 1);

    typedef struct packed {
        logic [1:0]                 r_valid;
        rename_pkg::arf_id_t [1:0]  areg;
        rename_pkg::rob_id_t [1:0]  preg;
        logic [1:0]                 check;
        rename_pkg::rob_id_t [3:0]  src_preg;
        rename_pkg::word_t [3:0]    arf_data;
        logic [3:0]                 data_valid;
        rename_pkg::word_t          pc;
    } issue_pkt_t;

    logic [OCC_W-1:0]                 occ_q;
    logic [OCC_W-1:0]                 occ_d;
    rename_pkg::rob_id_t              wr_ptr_q;
    rename_pkg::rob_id_t              wr_ptr_d;
    logic                             avail_q;
    logic                             avail_d;
    logic [1:0]                       issue;
    logic [1:0]                       spec_we;
    logic [1:0]                       ret_we;
    logic [1:0]                       n_issue;
    logic [1:0]                       n_retire;
    rename_pkg::rob_id_t [1:0]        alloc_id;
    rename_pkg::rat_entry_t [3:0]     spec_src;
    rename_pkg::rat_entry_t [5:0]     commit_rd;
    rename_pkg::rat_entry_t [1:0]     spec_new;
    rename_pkg::rat_entry_t [1:0]     commit_new;
    rename_pkg::word_t [3:0]          arf_rdata;
    issue_pkt_t                       pkt_d;
    issue_pkt_t                       pkt_q;

    // add modulo the reorder buffer size
    function automatic rename_pkg::rob_id_t rob_wrap(input rename_pkg::rob_id_t base,
                                                     input logic [1:0] inc);
        int sum;
        sum = int'(base) + int'(inc);
        if (sum >= ROB_DEPTH) begin
            sum = sum - ROB_DEPTH;
        end
        return rename_pkg::rob_id_t'(sum);
    endfunction

    assign dec_ready_o = avail_q & ~flush_i & ren_ready_i;
    assign issue       = dec_r_valid_i & {2{dec_valid_i & dec_ready_o}};

    assign alloc_id[0] = wr_ptr_q;
    assign alloc_id[1] = rob_wrap(wr_ptr_q, 2'd1);

    for (genvar i = 0; i < 2; i++) begin : g_lane
        assign spec_we[i] = issue[i] & dec_w_reg_i[i] & (dec_rd_i[i] != '0);
        assign ret_we[i]  = retire.valid[i] & retire.w_valid[i] & (retire.arf_id[i] != '0);

        // new mapping flips the committed check of rd
        assign spec_new[i].check    = ~commit_rd[4+i].check;
        assign spec_new[i].rob_id   = alloc_id[i];
        assign commit_new[i].check  = retire.check[i];
        assign commit_new[i].rob_id = retire.rob_id[i];
    end

    assign n_issue  = {1'b0, issue[0]} + {1'b0, issue[1]};
    assign n_retire = {1'b0, retire.valid[0]} + {1'b0, retire.valid[1]};

    always_comb begin
        occ_d    = occ_q + OCC_W'(n_issue) - OCC_W'(n_retire);
        wr_ptr_d = rob_wrap(wr_ptr_q, n_issue);
        avail_d  = int'(occ_d) <= ROB_DEPTH - rename_pkg::ROB_MARGIN;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occ_q    <= '0;
            wr_ptr_q <= '0;
            avail_q  <= 1'b1;
        end else if (flush_i) begin
            occ_q    <= '0;
            wr_ptr_q <= '0;
            avail_q  <= 1'b1;
        end else begin
            occ_q    <= occ_d;
            wr_ptr_q <= wr_ptr_d;
            avail_q  <= avail_d;
        end
    end

    map_table #(
        .R_PORTS (4),
        .FORWARD (1'b0)
    ) spec_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (flush_i),
        .raddr_i (dec_rs_i),
        .rdata_o (spec_src),
        .waddr_i (dec_rd_i),
        .we_i    (spec_we),
        .wdata_i (spec_new)
    );

    // ports 0..3 serve sources, 4..5 the destinations
    map_table #(
        .R_PORTS (6),
        .FORWARD (1'b1)
    ) commit_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (flush_i),
        .raddr_i ({dec_rd_i, dec_rs_i}),
        .rdata_o (commit_rd),
        .waddr_i (retire.arf_id),
        .we_i    (ret_we),
        .wdata_i (commit_new)
    );

    arf u_arf (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (dec_rs_i),
        .rdata_o (arf_rdata),
        .waddr_i (retire.arf_id),
        .we_i    (ret_we),
        .wdata_i (retire.data)
    );

    always_comb begin
        pkt_d.r_valid = issue;
        pkt_d.areg    = dec_rd_i;
        pkt_d.preg    = alloc_id;
        pkt_d.check   = {spec_new[1].check, spec_new[0].check};
        pkt_d.pc      = dec_pc_i;
        for (int j = 0; j < 4; j++) begin
            pkt_d.src_preg[j]   = spec_src[j].rob_id;
            pkt_d.arf_data[j]   = arf_rdata[j];
            // value sits in the arf when nothing newer is in flight
            pkt_d.data_valid[j] = ~dec_reg_need_i[j] | (spec_src[j] == commit_rd[j]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_q <= '0;
        end else if (flush_i) begin
            pkt_q <= '0;
        end else if (ren_ready_i) begin
            pkt_q <= pkt_d;
        end
    end

    assign ren_r_valid_o    = pkt_q.r_valid;
    assign ren_areg_o       = pkt_q.areg;
    assign ren_preg_o       = pkt_q.preg;
    assign ren_check_o      = pkt_q.check;
    assign ren_src_preg_o   = pkt_q.src_preg;
    assign ren_arf_data_o   = pkt_q.arf_data;
    assign ren_data_valid_o = pkt_q.data_valid;
    assign ren_pc_o         = pkt_q.pc;

    a_occ_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        int'(occ_q) <= ROB_DEPTH
    ) else $error("rename_stage: occupancy %0d above ROB depth", occ_q);

    // retirement from an empty ROB means the commit side lost track
    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (occ_q == '0) |-> (retire.valid == 2'b00)
    ) else $error("rename_stage: retire with empty ROB");

endmodule

`default_nettype wire

// File: hdl/rename_top.sv
`default_nettype none

module rename_top #(
    parameter int ROB_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    // decode side
    input  logic                          dec_valid_i,
    output logic                          dec_ready_o,
    input  logic [1:0]                    dec_r_valid_i,
    input  logic [1:0]                    dec_w_reg_i,
    input  rename_pkg::arf_id_t [3:0]     dec_rs_i,
    input  rename_pkg::arf_id_t [1:0]     dec_rd_i,
    input  logic [3:0]                    dec_reg_need_i,
    input  rename_pkg::word_t             dec_pc_i,
    // issue side
    input  logic                          ren_ready_i,
    output logic [1:0]                    ren_r_valid_o,
    output rename_pkg::arf_id_t [1:0]     ren_areg_o,
    output rename_pkg::rob_id_t [1:0]     ren_preg_o,
    output logic [1:0]                    ren_check_o,
    output rename_pkg::rob_id_t [3:0]     ren_src_preg_o,
    output rename_pkg::word_t [3:0]       ren_arf_data_o,
    output logic [3:0]                    ren_data_valid_o,
    output rename_pkg::word_t             ren_pc_o,
    // retire side
    input  logic [1:0]                    ret_valid_i,
    input  logic [1:0]                    ret_w_valid_i,
    input  logic [1:0]                    ret_check_i,
    input  rename_pkg::arf_id_t [1:0]     ret_arf_id_i,
    input  rename_pkg::rob_id_t [1:0]     ret_rob_id_i,
    input  rename_pkg::word_t [1:0]       ret_data_i
);

    retire_if ret_if ();

    assign ret_if.valid   = ret_valid_i;
    assign ret_if.w_valid = ret_w_valid_i;
    assign ret_if.check   = ret_check_i;
    assign ret_if.arf_id  = ret_arf_id_i;
    assign ret_if.rob_id  = ret_rob_id_i;
    assign ret_if.data    = ret_data_i;

    rename_stage #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_stage (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .retire           (ret_if.stage_mp),
        .dec_valid_i      (dec_valid_i),
        .dec_ready_o      (dec_ready_o),
        .dec_r_valid_i    (dec_r_valid_i),
        .dec_w_reg_i      (dec_w_reg_i),
        .dec_rs_i         (dec_rs_i),
        .dec_rd_i         (dec_rd_i),
        .dec_reg_need_i   (dec_reg_need_i),
        .dec_pc_i         (dec_pc_i),
        .ren_ready_i      (ren_ready_i),
        .ren_r_valid_o    (ren_r_valid_o),
        .ren_areg_o       (ren_areg_o),
        .ren_preg_o       (ren_preg_o),
        .ren_check_o      (ren_check_o),
        .ren_src_preg_o   (ren_src_preg_o),
        .ren_arf_data_o   (ren_arf_data_o),
        .ren_data_valid_o (ren_data_valid_o),
        .ren_pc_o         (ren_pc_o)
    );

endmodule

`default_nettype wire

// File: dv/rename_checker.sv
`default_nettype none

module rename_checker (
    input  logic              dec_ready_i,
    input  logic [1:0]        r_valid_i,
    input  logic [1:0][4:0]   areg_i,
    input  logic [1:0][5:0]   preg_i,
    input  logic [1:0]        check_i,
    input  logic [3:0][5:0]   src_preg_i,
    input  logic [3:0][31:0]  arf_data_i,
    input  logic [3:0]        data_valid_i,
    input  logic [31:0]       pc_i
);

    int err_cnt;
    int check_cnt;

    initial begin
        err_cnt   = 0;
        check_cnt = 0;
    end

    task automatic compare(input string name, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    // dec_ready belongs to the row now driven and the outputs to the row before
    always begin
        @(rename_tb.sample_ev);
        compare(rename_tb.cur_row.name, "dec_ready_o",
                32'(rename_tb.cur_row.exp_dec_ready), 32'(dec_ready_i));
        if (rename_tb.prev_valid) begin
            compare(rename_tb.prev_row.name, "ren_r_valid_o",
                    32'(rename_tb.prev_row.exp_rv), 32'(r_valid_i));
            compare(rename_tb.prev_row.name, "ren_data_valid_o",
                    32'(rename_tb.prev_row.exp_dv), 32'(data_valid_i));
            compare(rename_tb.prev_row.name, "ren_pc_o", rename_tb.prev_row.exp_pc, pc_i);
            for (int l = 0; l < 2; l++) begin
                if (rename_tb.prev_row.exp_rv[l]) begin
                    compare(rename_tb.prev_row.name, $sformatf("ren_preg_o[%0d]", l),
                            32'(rename_tb.prev_row.exp_preg[l]), 32'(preg_i[l]));
                    compare(rename_tb.prev_row.name, $sformatf("ren_areg_o[%0d]", l),
                            32'(rename_tb.prev_row.exp_areg[l]), 32'(areg_i[l]));
                end
                if (rename_tb.prev_row.exp_rv[l] && rename_tb.prev_row.exp_chk_en[l]) begin
                    compare(rename_tb.prev_row.name, $sformatf("ren_check_o[%0d]", l),
                            32'(rename_tb.prev_row.exp_chk[l]), 32'(check_i[l]));
                end
            end
            for (int j = 0; j < 4; j++) begin
                compare(rename_tb.prev_row.name, $sformatf("ren_src_preg_o[%0d]", j),
                        32'(rename_tb.prev_row.exp_src[j]), 32'(src_preg_i[j]));
                compare(rename_tb.prev_row.name, $sformatf("ren_arf_data_o[%0d]", j),
                        rename_tb.prev_row.exp_data[j], arf_data_i[j]);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/rename_tb.sv
`default_nettype none

module rename_tb;

    typedef struct {
        string            name;
        logic             dvalid;
        logic [1:0]       rv;
        logic [1:0]       wreg;
        logic [3:0][4:0]  rs;
        logic [1:0][4:0]  rd;
        logic [3:0]       need;
        logic [31:0]      pc;
        logic [1:0]       ret_v;
        logic [1:0]       ret_wv;
        logic [1:0]       ret_chk;
        logic [1:0][4:0]  ret_arf;
        logic [1:0][5:0]  ret_rob;
        logic [1:0][31:0] ret_data;
        logic             ready;
        logic             flush;
        logic             wait_rdy;
        logic [1:0]       exp_rv;
        logic [1:0][4:0]  exp_areg;
        logic [1:0][5:0]  exp_preg;
        logic [1:0]       exp_chk;
        logic [1:0]       exp_chk_en;
        logic [3:0][5:0]  exp_src;
        logic [3:0]       exp_dv;
        logic [3:0][31:0] exp_data;
        logic [31:0]      exp_pc;
        logic             exp_dec_ready;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             dec_valid;
    logic             dec_ready;
    logic [1:0]       dec_r_valid;
    logic [1:0]       dec_w_reg;
    logic [3:0][4:0]  dec_rs;
    logic [1:0][4:0]  dec_rd;
    logic [3:0]       dec_reg_need;
    logic [31:0]      dec_pc;
    logic             ren_ready;
    logic [1:0]       ren_r_valid;
    logic [1:0][4:0]  ren_areg;
    logic [1:0][5:0]  ren_preg;
    logic [1:0]       ren_check;
    logic [3:0][5:0]  ren_src_preg;
    logic [3:0][31:0] ren_arf_data;
    logic [3:0]       ren_data_valid;
    logic [31:0]      ren_pc;
    logic [1:0]       ret_valid;
    logic [1:0]       ret_w_valid;
    logic [1:0]       ret_check;
    logic [1:0][4:0]  ret_arf_id;
    logic [1:0][5:0]  ret_rob_id;
    logic [1:0][31:0] ret_data;

    row_t rows[$];
    row_t cur_row;
    row_t prev_row;
    bit   prev_valid;
    int   timeouts;
    int   seed;
    event sample_ev;

    rename_top #(.ROB_DEPTH(64)) dut0 (
        .clk(clk), .rst_n_i(rst_n), .flush_i(flush),
        .dec_valid_i(dec_valid), .dec_ready_o(dec_ready),
        .dec_r_valid_i(dec_r_valid), .dec_w_reg_i(dec_w_reg),
        .dec_rs_i(dec_rs), .dec_rd_i(dec_rd),
        .dec_reg_need_i(dec_reg_need), .dec_pc_i(dec_pc),
        .ren_ready_i(ren_ready), .ren_r_valid_o(ren_r_valid),
        .ren_areg_o(ren_areg), .ren_preg_o(ren_preg), .ren_check_o(ren_check),
        .ren_src_preg_o(ren_src_preg), .ren_arf_data_o(ren_arf_data),
        .ren_data_valid_o(ren_data_valid), .ren_pc_o(ren_pc),
        .ret_valid_i(ret_valid), .ret_w_valid_i(ret_w_valid),
        .ret_check_i(ret_check), .ret_arf_id_i(ret_arf_id),
        .ret_rob_id_i(ret_rob_id), .ret_data_i(ret_data)
    );

    rename_checker chk0 (
        .dec_ready_i(dec_ready), .r_valid_i(ren_r_valid), .areg_i(ren_areg),
        .preg_i(ren_preg), .check_i(ren_check), .src_preg_i(ren_src_preg),
        .arf_data_i(ren_arf_data), .data_valid_i(ren_data_valid), .pc_i(ren_pc)
    );

    always #20 clk = ~clk;

    // plain bundle without retire and with unneeded r0 sources
    function automatic row_t new_row(input string name, input logic dvalid,
                                     input logic [1:0] rv, input logic [1:0] wreg,
                                     input logic [4:0] rd0, input logic [4:0] rd1);
        row_t r;
        r.name          = name;
        r.dvalid        = dvalid;
        r.rv            = rv;
        r.wreg          = wreg;
        r.rs            = '0;
        r.rd[0]         = rd0;
        r.rd[1]         = rd1;
        r.need          = 4'b0000;
        r.pc            = $random(seed);
        r.ret_v         = 2'b00;
        r.ret_wv        = 2'b00;
        r.ret_chk       = 2'b00;
        r.ret_arf       = '0;
        r.ret_rob       = '0;
        r.ret_data      = '0;
        r.ready         = 1'b1;
        r.flush         = 1'b0;
        r.wait_rdy      = 1'b0;
        r.exp_rv        = dvalid ? rv : 2'b00;
        r.exp_areg      = r.rd;
        r.exp_preg      = '0;
        // rename flips a committed check that is still zero
        r.exp_chk       = 2'b11;
        r.exp_chk_en    = r.exp_rv & wreg & {rd1 != 5'd0, rd0 != 5'd0};
        r.exp_src       = '0;
        r.exp_dv        = 4'b1111;
        r.exp_data      = '0;
        r.exp_pc        = r.pc;
        r.exp_dec_ready = 1'b1;
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        logic [31:0] d1;
        logic [31:0] d2;
        d1 = 32'hcafe_0001;
        d2 = 32'h0000_5a5a;
        r = new_row("alloc_pair_a", 1'b1, 2'b11, 2'b11, 5'd1, 5'd2);
        r.exp_preg[0] = 6'd0;
        r.exp_preg[1] = 6'd1;
        rows.push_back(r);
        r = new_row("alloc_pair_b", 1'b1, 2'b11, 2'b11, 5'd3, 5'd4);
        r.exp_preg[0] = 6'd2;
        r.exp_preg[1] = 6'd3;
        rows.push_back(r);
        r = new_row("alloc_single", 1'b1, 2'b01, 2'b01, 5'd5, 5'd0);
        r.exp_preg[0] = 6'd4;
        rows.push_back(r);
        // r5 still in flight and r6 never renamed while r1 retires in this same cycle
        r = new_row("retire_fwd", 1'b1, 2'b01, 2'b00, 5'd0, 5'd0);
        r.rs[0] = 5'd5;
        r.rs[1] = 5'd6;
        r.rs[2] = 5'd1;
        r.need = 4'b0111;
        r.ret_v = 2'b01;
        r.ret_wv = 2'b01;
        r.ret_chk = 2'b01;
        r.ret_arf[0] = 5'd1;
        r.ret_rob[0] = 6'd0;
        r.ret_data[0] = d1;
        r.exp_preg[0] = 6'd5;
        r.exp_src[0] = 6'd4;
        r.exp_dv = 4'b1110;
        r.exp_data[2] = d1;
        rows.push_back(r);
        r = new_row("retire_r5", 1'b0, 2'b00, 2'b00, 5'd0, 5'd0);
        r.rs[0] = 5'd5;
        r.need = 4'b0001;
        r.ret_v = 2'b01;
        r.ret_wv = 2'b01;
        r.ret_chk = 2'b01;
        r.ret_arf[0] = 5'd5;
        r.ret_rob[0] = 6'd4;
        r.ret_data[0] = d2;
        r.exp_src[0] = 6'd4;
        r.exp_data[0] = d2;
        rows.push_back(r);
        // r1 committed with check 1 and renames back to 0
        r = new_row("read_r5", 1'b1, 2'b01, 2'b01, 5'd1, 5'd0);
        r.rs[0] = 5'd5;
        r.need = 4'b0001;
        r.exp_preg[0] = 6'd6;
        r.exp_chk[0] = 1'b0;
        r.exp_src[0] = 6'd4;
        r.exp_data[0] = d2;
        rows.push_back(r);
        // outputs hold what read_r5 produced
        r = new_row("stall", 1'b1, 2'b11, 2'b11, 5'd7, 5'd8);
        r.ready = 1'b0;
        r.exp_dec_ready = 1'b0;
        r.exp_rv = rows[rows.size()-1].exp_rv;
        r.exp_areg = rows[rows.size()-1].exp_areg;
        r.exp_preg = rows[rows.size()-1].exp_preg;
        r.exp_chk = rows[rows.size()-1].exp_chk;
        r.exp_chk_en = rows[rows.size()-1].exp_chk_en;
        r.exp_src = rows[rows.size()-1].exp_src;
        r.exp_dv = rows[rows.size()-1].exp_dv;
        r.exp_data = rows[rows.size()-1].exp_data;
        r.exp_pc = rows[rows.size()-1].exp_pc;
        rows.push_back(r);
        r = new_row("stall_release", 1'b1, 2'b11, 2'b11, 5'd7, 5'd8);
        r.exp_preg[0] = 6'd7;
        r.exp_preg[1] = 6'd8;
        rows.push_back(r);
        r = new_row("flush", 1'b1, 2'b11, 2'b11, 5'd7, 5'd8);
        r.flush = 1'b1;
        r.exp_dec_ready = 1'b0;
        r.exp_rv = 2'b00;
        r.exp_dv = 4'b0000;
        r.exp_pc = 32'h0;
        rows.push_back(r);
        // arf keeps r1 and r5 across the flush
        r = new_row("post_flush", 1'b1, 2'b11, 2'b11, 5'd9, 5'd10);
        r.rs[0] = 5'd1;
        r.rs[1] = 5'd5;
        r.rs[2] = 5'd12;
        r.need = 4'b1111;
        r.exp_preg[0] = 6'd0;
        r.exp_preg[1] = 6'd1;
        r.exp_data[0] = d1;
        r.exp_data[1] = d2;
        rows.push_back(r);
        for (int k = 1; k <= 30; k++) begin
            r = new_row($sformatf("fill_%0d", k), 1'b1, 2'b11, 2'b11, 5'd20, 5'd21);
            r.exp_preg[0] = 6'(2 * k);
            r.exp_preg[1] = 6'(2 * k + 1);
            rows.push_back(r);
        end
        r = new_row("rob_full", 1'b1, 2'b11, 2'b11, 5'd20, 5'd21);
        r.exp_dec_ready = 1'b0;
        r.exp_rv = 2'b00;
        rows.push_back(r);
        r = new_row("retire_one", 1'b0, 2'b00, 2'b00, 5'd0, 5'd0);
        r.ret_v = 2'b01;
        r.ret_rob[0] = 6'd0;
        r.exp_dec_ready = 1'b0;
        rows.push_back(r);
        r = new_row("retire_two", 1'b0, 2'b00, 2'b00, 5'd0, 5'd0);
        r.ret_v = 2'b11;
        r.ret_rob[0] = 6'd1;
        r.ret_rob[1] = 6'd2;
        r.exp_dec_ready = 1'b0;
        rows.push_back(r);
        r = new_row("refill", 1'b1, 2'b01, 2'b01, 5'd22, 5'd0);
        r.wait_rdy = 1'b1;
        r.exp_preg[0] = 6'd62;
        rows.push_back(r);
        r = new_row("wrap", 1'b1, 2'b11, 2'b11, 5'd23, 5'd24);
        r.exp_preg[0] = 6'd63;
        r.exp_preg[1] = 6'd0;
        rows.push_back(r);
        r = new_row("idle_end", 1'b0, 2'b00, 2'b00, 5'd0, 5'd0);
        r.exp_dec_ready = 1'b0;
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        dec_valid    = r.dvalid;
        dec_r_valid  = r.rv;
        dec_w_reg    = r.wreg;
        dec_rs       = r.rs;
        dec_rd       = r.rd;
        dec_reg_need = r.need;
        dec_pc       = r.pc;
        ret_valid    = r.ret_v;
        ret_w_valid  = r.ret_wv;
        ret_check    = r.ret_chk;
        ret_arf_id   = r.ret_arf;
        ret_rob_id   = r.ret_rob;
        ret_data     = r.ret_data;
        ren_ready    = r.ready;
        flush        = r.flush;
    endtask

    task automatic wait_dec_ready();
        int n;
        n = 0;
        #1;
        while (dec_ready !== 1'b1 && n < 50) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (dec_ready !== 1'b1) begin
            timeouts++;
            $display("timeout: dec_ready_o stayed low for 50 cycles");
        end
    endtask

    initial begin
        seed       = 32'h92d;
        timeouts   = 0;
        prev_valid = 1'b0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        build_table();
        drive_row(new_row("idle", 1'b0, 2'b00, 2'b00, 5'd0, 5'd0));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_dec_ready();
        foreach (rows[i]) begin
            @(negedge clk);
            cur_row = rows[i];
            drive_row(cur_row);
            if (cur_row.wait_rdy) begin
                wait_dec_ready();
            end
            #10;
            ->sample_ev;
            #1;
            prev_row   = cur_row;
            prev_valid = 1'b1;
        end
        @(negedge clk);
        $display("checks=%0d errors=%0d timeouts=%0d", chk0.check_cnt, chk0.err_cnt, timeouts);
        if (chk0.err_cnt == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/rename_pkg.sv
hdl/retire_if.sv
hdl/map_table.sv
hdl/arf.sv
hdl/rename_stage.sv
hdl/rename_top.sv
dv/rename_checker.sv
dv/rename_tb.sv

// File: run.sh
#!/bin/bash
# build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module rename_tb \
    -o rename_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rename_sim > sim.log 2>&1
cat sim.log

grep -qx "SIMULATION PASSED" sim.log && exit 0 || exit 1
